// File: dv/hdmi_tb.sv
`include "hdmi_defs.svh"

module hdmi_tb;

	localparam int clk_period = 40;
	localparam int h_active = 16;
	localparam int h_fp = 2;
	localparam int h_sync = 3;
	localparam int h_bp = 4;
	localparam int v_active = 6;
	localparam int v_fp = 1;
	localparam int v_sync = 2;
	localparam int v_bp = 2;
	localparam int h_total = h_active + h_fp + h_sync + h_bp;
	localparam int v_total = v_active + v_fp + v_sync + v_bp;
	localparam int frame_cycles = h_total * v_total;
	localparam int watchdog_cycles = 3 * frame_cycles + 200;

	logic clk_pix_p;
	logic reset;
	logic s_read;
	logic s_write;
	logic [`HDMI_ADDR_W-1:0] s_address;
	logic [`HDMI_DATA_W-1:0] s_writedata;
	logic [`HDMI_BE_W-1:0] s_byteenable;
	logic s_waitrequest;
	logic s_readdatavalid;
	logic [`HDMI_DATA_W-1:0] s_readdata;
	logic [9:0] tmds_red;
	logic [9:0] tmds_green;
	logic [9:0] tmds_blue;
	logic [`HDMI_POS_W-1:0] x;
	logic [`HDMI_POS_W-1:0] y;

	// shadow registers and delay lines for the expected video
	logic [31:0] shadow_ctrl;
	logic [31:0] shadow_color;
	logic rd_pending;
	logic [31:0] exp_rdata;
	logic [`HDMI_POS_W-1:0] x_hist [1:3];
	logic [`HDMI_POS_W-1:0] y_hist [1:3];
	logic en_hist [1:3];
	logic [31:0] color_hist [1:2];
	logic [31:0] rng_state;
	logic exp_de;
	logic exp_hs;
	logic exp_vs;

	tb_clock #(
		.period(clk_period),
		.reset_cycles(3)
	) u_clock (
		.clk_pix_p(clk_pix_p),
		.reset(reset)
	);

	hdmi_tx #(
		.h_active(h_active),
		.h_fp(h_fp),
		.h_sync(h_sync),
		.h_bp(h_bp),
		.v_active(v_active),
		.v_fp(v_fp),
		.v_sync(v_sync),
		.v_bp(v_bp)
	) u_hdmi_tx (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.s_read(s_read),
		.s_write(s_write),
		.s_address(s_address),
		.s_writedata(s_writedata),
		.s_byteenable(s_byteenable),
		.s_waitrequest(s_waitrequest),
		.s_readdatavalid(s_readdatavalid),
		.s_readdata(s_readdata),
		.tmds_red(tmds_red),
		.tmds_green(tmds_green),
		.tmds_blue(tmds_blue),
		.x(x),
		.y(y)
	);

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic logic [31:0] merge_bytes(
		input logic [31:0] old_word,
		input logic [31:0] data,
		input logic [3:0] be
	);
		logic [31:0] mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_word & ~mask) | (data & mask);
	endfunction

	function automatic logic [31:0] reg_value(input logic [`HDMI_ADDR_W-1:0] addr);
		case (addr)
			`HDMI_REG_CTRL: return shadow_ctrl;
			`HDMI_REG_COLOR: return shadow_color;
			default: return '0;
		endcase
	endfunction

	// undo the optional inversion and then the xor or xnor chain
	function automatic logic [7:0] tmds_decode(input logic [9:0] sym);
		logic [7:0] d;
		logic [7:0] b;
		d = sym[9] ? ~sym[7:0] : sym[7:0];
		b[0] = d[0];
		for (int i = 1; i < 8; i++) begin
			b[i] = sym[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		end
		return b;
	endfunction

	function automatic logic [9:0] ctrl_symbol(input logic vs, input logic hs);
		case ({vs, hs})
			2'b01: return 10'b0010101011;
			2'b10: return 10'b0101010100;
			2'b11: return 10'b1010101011;
			default: return 10'b1101010100;
		endcase
	endfunction

	function automatic logic [`HDMI_POS_W-1:0] next_x(input logic [`HDMI_POS_W-1:0] cx);
		if (int'(cx) == h_total - 1) begin
			return '0;
		end else begin
			return cx + 1'b1;
		end
	endfunction

	function automatic logic [`HDMI_POS_W-1:0] next_y(
		input logic [`HDMI_POS_W-1:0] cx,
		input logic [`HDMI_POS_W-1:0] cy
	);
		if (int'(cx) != h_total - 1) begin
			return cy;
		end else if (int'(cy) == v_total - 1) begin
			return '0;
		end else begin
			return cy + 1'b1;
		end
	endfunction

	task automatic report_error(input string what);
		$display("Error: %0t: %s", $time, what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic write_reg(
		input logic [`HDMI_ADDR_W-1:0] addr,
		input logic [31:0] data,
		input logic [3:0] be
	);
		@(posedge clk_pix_p);
		s_write <= 1'b1;
		s_address <= addr;
		s_writedata <= data;
		s_byteenable <= be;
		@(posedge clk_pix_p);
		s_write <= 1'b0;
	endtask

	task automatic read_reg(input logic [`HDMI_ADDR_W-1:0] addr);
		@(posedge clk_pix_p);
		s_read <= 1'b1;
		s_address <= addr;
		@(posedge clk_pix_p);
		s_read <= 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_pix_p);
	endtask

	always_ff @(posedge clk_pix_p) begin
		if (reset) begin
			shadow_ctrl <= '0;
			shadow_color <= '0;
			rd_pending <= 1'b0;
			exp_rdata <= '0;
			for (int i = 1; i <= 3; i++) begin
				x_hist[i] <= '0;
				y_hist[i] <= '0;
				en_hist[i] <= 1'b0;
			end
			color_hist[1] <= '0;
			color_hist[2] <= '0;
		end else begin
			if (s_write && s_address == `HDMI_REG_CTRL) begin
				shadow_ctrl <= merge_bytes(shadow_ctrl, s_writedata, s_byteenable);
			end
			if (s_write && s_address == `HDMI_REG_COLOR) begin
				shadow_color <= merge_bytes(shadow_color, s_writedata, s_byteenable);
			end
			rd_pending <= s_read;
			if (s_read) begin
				exp_rdata <= reg_value(s_address);
			end
			x_hist[1] <= x;
			y_hist[1] <= y;
			en_hist[1] <= shadow_ctrl[0];
			for (int i = 2; i <= 3; i++) begin
				x_hist[i] <= x_hist[i-1];
				y_hist[i] <= y_hist[i-1];
				en_hist[i] <= en_hist[i-1];
			end
			color_hist[1] <= shadow_color;
			color_hist[2] <= color_hist[1];
		end
	end

	// position three cycles back decides what the symbols carry now
	always_comb begin
		exp_de = en_hist[3] && int'(x_hist[3]) < h_active && int'(y_hist[3]) < v_active;
		exp_hs = en_hist[3] && int'(x_hist[3]) >= h_active + h_fp
			&& int'(x_hist[3]) < h_active + h_fp + h_sync;
		exp_vs = en_hist[3] && int'(y_hist[3]) >= v_active + v_fp
			&& int'(y_hist[3]) < v_active + v_fp + v_sync;
	end

	a_no_waitrequest: assert property (@(posedge clk_pix_p) disable iff (reset)
		!s_waitrequest) else report_error("s_waitrequest went high");

	a_readdatavalid: assert property (@(posedge clk_pix_p) disable iff (reset)
		s_readdatavalid == rd_pending)
		else report_error("s_readdatavalid does not follow the read by one cycle");

	a_readdata: assert property (@(posedge clk_pix_p) disable iff (reset)
		rd_pending |-> s_readdata == exp_rdata)
		else report_error($sformatf("read data %h, expected %h",
			$sampled(s_readdata), $sampled(exp_rdata)));

	a_idle_hold: assert property (@(posedge clk_pix_p) disable iff (reset)
		!en_hist[1] |-> (x == '0 && y == '0))
		else report_error("counters moved while video was disabled");

	a_x_step: assert property (@(posedge clk_pix_p) disable iff (reset)
		en_hist[1] |-> x == next_x(x_hist[1]))
		else report_error($sformatf("x is %0d after %0d",
			$sampled(x), $sampled(x_hist[1])));

	a_y_step: assert property (@(posedge clk_pix_p) disable iff (reset)
		en_hist[1] |-> y == next_y(x_hist[1], y_hist[1]))
		else report_error($sformatf("y is %0d after %0d",
			$sampled(y), $sampled(y_hist[1])));

	a_red_data: assert property (@(posedge clk_pix_p) disable iff (reset)
		exp_de |-> tmds_decode(tmds_red) == color_hist[2][7:0])
		else report_error("red symbol does not decode to the red byte");

	a_green_data: assert property (@(posedge clk_pix_p) disable iff (reset)
		exp_de |-> tmds_decode(tmds_green) == color_hist[2][15:8])
		else report_error("green symbol does not decode to the green byte");

	a_blue_data: assert property (@(posedge clk_pix_p) disable iff (reset)
		exp_de |-> tmds_decode(tmds_blue) == color_hist[2][23:16])
		else report_error("blue symbol does not decode to the blue byte");

	a_red_blank: assert property (@(posedge clk_pix_p) disable iff (reset)
		!exp_de |-> tmds_red == ctrl_symbol(1'b0, 1'b0))
		else report_error($sformatf("red blanking symbol %b", $sampled(tmds_red)));

	a_green_blank: assert property (@(posedge clk_pix_p) disable iff (reset)
		!exp_de |-> tmds_green == ctrl_symbol(1'b0, 1'b0))
		else report_error($sformatf("green blanking symbol %b", $sampled(tmds_green)));

	a_blue_blank: assert property (@(posedge clk_pix_p) disable iff (reset)
		!exp_de |-> tmds_blue == ctrl_symbol(exp_vs, exp_hs))
		else report_error($sformatf("blue blanking symbol %b", $sampled(tmds_blue)));

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	initial begin
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		s_byteenable = '0;
		rng_state = 32'h70042b68;
		@(posedge clk_pix_p);
		while (reset) @(posedge clk_pix_p);

		for (int a = 0; a < 4; a++) begin
			read_reg(`HDMI_ADDR_W'(a));
		end
		wait_cycles(10);

		rng_state = next_rand(rng_state);
		write_reg(`HDMI_REG_COLOR, rng_state, 4'b1111);
		write_reg(`HDMI_REG_CTRL, 32'h0000_0001, 4'b0001);

		// one colour per frame with green kept in the second
		for (int f = 0; f < 2; f++) begin
			rng_state = next_rand(rng_state);
			write_reg(`HDMI_REG_COLOR, rng_state, (f == 0) ? 4'b1111 : 4'b0101);
			wait_cycles(frame_cycles - 2);
		end

		// enable stays set as only the upper control bytes are written
		write_reg(`HDMI_REG_CTRL, 32'hdead_be00, 4'b1110);
		for (int a = 0; a < 4; a++) begin
			read_reg(`HDMI_ADDR_W'(a));
		end
		wait_cycles(4);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: dv/tb_clock.sv
module tb_clock #(
	parameter int period = 40,
	parameter int reset_cycles = 3
) (
	output logic clk_pix_p,
	output logic reset
);

	initial begin
		clk_pix_p = 1'b0;
		forever #(period / 2) clk_pix_p = ~clk_pix_p;
	end

	// reset released on a rising edge after reset_cycles cycles
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_pix_p);
		reset <= 1'b0;
	end

endmodule

// File: hdmi.f
+incdir+rtl
rtl/hdmi_pkg.sv
rtl/hdmi_regs.sv
rtl/video_timing.sv
rtl/tmds_encoder.sv
rtl/hdmi_tx.sv
dv/tb_clock.sv
dv/hdmi_tb.sv

// File: rtl/hdmi_defs.svh
`ifndef HDMI_DEFS_SVH
`define HDMI_DEFS_SVH

// default horizontal timing, 1024 active pixels
`define HDMI_H_ACTIVE 1024
`define HDMI_H_FP 18
`define HDMI_H_SYNC 60
`define HDMI_H_BP 112

// default vertical timing, 600 active lines
`define HDMI_V_ACTIVE 600
`define HDMI_V_FP 18
`define HDMI_V_SYNC 60
`define HDMI_V_BP 112

// pixel and line counter width
`define HDMI_POS_W 11

// memory-mapped slave widths
`define HDMI_ADDR_W 2
`define HDMI_DATA_W 32
`define HDMI_BE_W 4

// register map
`define HDMI_REG_CTRL 2'd0
`define HDMI_REG_COLOR 2'd1

`endif

// File: rtl/hdmi_pkg.sv
package hdmi_pkg;

	// control register, only bit 0 is live
	typedef struct packed {
		logic [30:0] reserved;
		logic enable;
	} mm_ctrl_t;

	// fill colour, red in the lowest byte
	typedef struct packed {
		logic [7:0] spare;
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} mm_color_t;

	// one bus word, read as control or as colour depending on the address
	typedef union packed {
		mm_ctrl_t ctrl;
		mm_color_t color;
	} mm_word_u;

	// control period bits, c1 then c0 on the blue channel
	typedef struct packed {
		logic vsync;
		logic hsync;
	} tmds_ctrl_t;

endpackage

// File: rtl/hdmi_regs.sv
`include "hdmi_defs.svh"

module hdmi_regs
	import hdmi_pkg::*;
(
	input logic clk_pix_p,
	input logic reset,
	input logic s_read,
	input logic s_write,
	input logic [`HDMI_ADDR_W-1:0] s_address,
	input logic [`HDMI_DATA_W-1:0] s_writedata,
	input logic [`HDMI_BE_W-1:0] s_byteenable,
	output logic s_waitrequest,
	output logic s_readdatavalid,
	output logic [`HDMI_DATA_W-1:0] s_readdata,
	output logic video_en,
	output logic [7:0] color_red,
	output logic [7:0] color_green,
	output logic [7:0] color_blue
);

	mm_word_u ctrl_reg;
	mm_word_u color_reg;
	logic [`HDMI_DATA_W-1:0] rd_word;

	function automatic logic [`HDMI_DATA_W-1:0] byte_merge(
		input logic [`HDMI_DATA_W-1:0] old_word,
		input logic [`HDMI_DATA_W-1:0] new_word,
		input logic [`HDMI_BE_W-1:0] be
	);
		logic [`HDMI_DATA_W-1:0] merged;
		merged = old_word;
		for (int i = 0; i < `HDMI_BE_W; i++) begin
			if (be[i]) begin
				merged[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return merged;
	endfunction

	// every access completes in the cycle it is presented
	assign s_waitrequest = 1'b0;

	always_comb begin
		case (s_address)
			`HDMI_REG_CTRL: rd_word = ctrl_reg;
			`HDMI_REG_COLOR: rd_word = color_reg;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_pix_p) begin
		if (reset) begin
			s_readdatavalid <= 1'b0;
			ctrl_reg <= '0;
			color_reg <= '0;
		end else begin
			s_readdatavalid <= s_read;
			if (s_write && s_address == `HDMI_REG_CTRL) begin
				ctrl_reg <= byte_merge(ctrl_reg, s_writedata, s_byteenable);
			end
			if (s_write && s_address == `HDMI_REG_COLOR) begin
				color_reg <= byte_merge(color_reg, s_writedata, s_byteenable);
			end
		end
	end

	always_ff @(posedge clk_pix_p) begin
		if (s_read) begin
			s_readdata <= rd_word;
		end
	end

	assign video_en = ctrl_reg.ctrl.enable;
	assign color_red = color_reg.color.red;
	assign color_green = color_reg.color.green;
	assign color_blue = color_reg.color.blue;

	a_rdv_one_cycle: assert property (@(posedge clk_pix_p) disable iff (reset)
		s_readdatavalid == ($past(s_read) && !$past(reset)));

	a_no_rd_wr_overlap: assert property (@(posedge clk_pix_p) disable iff (reset)
		!(s_read && s_write));

endmodule

// File: rtl/hdmi_tx.sv
`include "hdmi_defs.svh"

module hdmi_tx
	import hdmi_pkg::*;
#(
	parameter int h_active = `HDMI_H_ACTIVE,
	parameter int h_fp = `HDMI_H_FP,
	parameter int h_sync = `HDMI_H_SYNC,
	parameter int h_bp = `HDMI_H_BP,
	parameter int v_active = `HDMI_V_ACTIVE,
	parameter int v_fp = `HDMI_V_FP,
	parameter int v_sync = `HDMI_V_SYNC,
	parameter int v_bp = `HDMI_V_BP
) (
	input logic clk_pix_p,
	input logic reset,
	input logic s_read,
	input logic s_write,
	input logic [`HDMI_ADDR_W-1:0] s_address,
	input logic [`HDMI_DATA_W-1:0] s_writedata,
	input logic [`HDMI_BE_W-1:0] s_byteenable,
	output logic s_waitrequest,
	output logic s_readdatavalid,
	output logic [`HDMI_DATA_W-1:0] s_readdata,
	output logic [9:0] tmds_red,
	output logic [9:0] tmds_green,
	output logic [9:0] tmds_blue,
	output logic [`HDMI_POS_W-1:0] x,
	output logic [`HDMI_POS_W-1:0] y
);

	logic video_en;
	logic [7:0] color_red;
	logic [7:0] color_green;
	logic [7:0] color_blue;
	logic de;
	tmds_ctrl_t ctrl;
	tmds_ctrl_t ctrl_none;

	// sync only rides on the blue channel
	assign ctrl_none = '0;

	hdmi_regs u_regs (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.s_read(s_read),
		.s_write(s_write),
		.s_address(s_address),
		.s_writedata(s_writedata),
		.s_byteenable(s_byteenable),
		.s_waitrequest(s_waitrequest),
		.s_readdatavalid(s_readdatavalid),
		.s_readdata(s_readdata),
		.video_en(video_en),
		.color_red(color_red),
		.color_green(color_green),
		.color_blue(color_blue)
	);

	video_timing #(
		.h_active(h_active),
		.h_fp(h_fp),
		.h_sync(h_sync),
		.h_bp(h_bp),
		.v_active(v_active),
		.v_fp(v_fp),
		.v_sync(v_sync),
		.v_bp(v_bp)
	) u_timing (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.video_en(video_en),
		.x(x),
		.y(y),
		.de(de),
		.ctrl(ctrl)
	);

	tmds_encoder u_enc_red (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.de(de),
		.ctrl(ctrl_none),
		.color(color_red),
		.tmds(tmds_red)
	);

	tmds_encoder u_enc_green (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.de(de),
		.ctrl(ctrl_none),
		.color(color_green),
		.tmds(tmds_green)
	);

	tmds_encoder u_enc_blue (
		.clk_pix_p(clk_pix_p),
		.reset(reset),
		.de(de),
		.ctrl(ctrl),
		.color(color_blue),
		.tmds(tmds_blue)
	);

endmodule

// File: rtl/tmds_encoder.sv
module tmds_encoder
	import hdmi_pkg::*;
(
	input logic clk_pix_p,
	input logic reset,
	input logic de,
	input tmds_ctrl_t ctrl,
	input logic [7:0] color,
	output logic [9:0] tmds
);

	localparam logic [9:0] ctrl_sym_00 = 10'b1101010100;
	localparam logic [9:0] ctrl_sym_01 = 10'b0010101011;
	localparam logic [9:0] ctrl_sym_10 = 10'b0101010100;
	localparam logic [9:0] ctrl_sym_11 = 10'b1010101011;

	logic [3:0] ones_in;
	logic use_xnor;
	logic [8:0] qm_d;
	logic de_s1;
	tmds_ctrl_t ctrl_s1;
	logic [8:0] qm_s1;
	logic signed [4:0] bal;
	logic signed [4:0] disp;
	logic signed [4:0] disp_nxt;
	logic [9:0] sym_nxt;

	// transition minimising stage
	always_comb begin
		ones_in = 4'($countones(color));
		use_xnor = (ones_in > 4'd4) || (ones_in == 4'd4 && !color[0]);
		qm_d[0] = color[0];
		for (int i = 1; i < 8; i++) begin
			qm_d[i] = use_xnor ? ~(qm_d[i-1] ^ color[i]) : (qm_d[i-1] ^ color[i]);
		end
		qm_d[8] = ~use_xnor;
	end

	always_ff @(posedge clk_pix_p) begin
		if (reset) begin
			de_s1 <= 1'b0;
			ctrl_s1 <= '0;
		end else begin
			de_s1 <= de;
			ctrl_s1 <= ctrl;
		end
	end

	always_ff @(posedge clk_pix_p) begin
		qm_s1 <= qm_d;
	end

	// ones minus zeros of the minimised byte
	assign bal = 5'(2 * $countones(qm_s1[7:0])) - 5'sd8;

	// dc balancing stage
	always_comb begin
		sym_nxt = ctrl_sym_00;
		disp_nxt = disp;
		if (!de_s1) begin
			case (ctrl_s1)
				2'b01: sym_nxt = ctrl_sym_01;
				2'b10: sym_nxt = ctrl_sym_10;
				2'b11: sym_nxt = ctrl_sym_11;
				default: sym_nxt = ctrl_sym_00;
			endcase
			disp_nxt = '0;
		end else if (disp == 0 || bal == 0) begin
			sym_nxt = {~qm_s1[8], qm_s1[8], qm_s1[8] ? qm_s1[7:0] : ~qm_s1[7:0]};
			disp_nxt = qm_s1[8] ? disp + bal : disp - bal;
		end else if ((disp > 0 && bal > 0) || (disp < 0 && bal < 0)) begin
			// invert to pull the running disparity back towards zero
			sym_nxt = {1'b1, qm_s1[8], ~qm_s1[7:0]};
			disp_nxt = disp - bal + (qm_s1[8] ? 5'sd2 : 5'sd0);
		end else begin
			sym_nxt = {1'b0, qm_s1[8], qm_s1[7:0]};
			disp_nxt = disp + bal - (qm_s1[8] ? 5'sd0 : 5'sd2);
		end
	end

	always_ff @(posedge clk_pix_p) begin
		if (reset) begin
			tmds <= ctrl_sym_00;
			disp <= '0;
		end else begin
			tmds <= sym_nxt;
			disp <= disp_nxt;
		end
	end

	a_disp_range: assert property (@(posedge clk_pix_p) disable iff (reset)
		(disp >= -5'sd8) && (disp <= 5'sd8));

endmodule

// File: rtl/video_timing.sv
`include "hdmi_defs.svh"

module video_timing
	import hdmi_pkg::*;
#(
	parameter int h_active = `HDMI_H_ACTIVE,
	parameter int h_fp = `HDMI_H_FP,
	parameter int h_sync = `HDMI_H_SYNC,
	parameter int h_bp = `HDMI_H_BP,
	parameter int v_active = `HDMI_V_ACTIVE,
	parameter int v_fp = `HDMI_V_FP,
	parameter int v_sync = `HDMI_V_SYNC,
	parameter int v_bp = `HDMI_V_BP
) (
	input logic clk_pix_p,
	input logic reset,
	input logic video_en,
	output logic [`HDMI_POS_W-1:0] x,
	output logic [`HDMI_POS_W-1:0] y,
	output logic de,
	output tmds_ctrl_t ctrl
);

	localparam int h_total = h_active + h_fp + h_sync + h_bp;
	localparam int v_total = v_active + v_fp + v_sync + v_bp;
	localparam int h_sync_start = h_active + h_fp;
	localparam int v_sync_start = v_active + v_fp;

	logic x_wrap;
	logic y_wrap;

	assign x_wrap = (x == `HDMI_POS_W'(h_total - 1));
	assign y_wrap = (y == `HDMI_POS_W'(v_total - 1));

	// counters park at the top left corner while video is off
	always_ff @(posedge clk_pix_p) begin
		if (reset || !video_en) begin
			x <= '0;
			y <= '0;
		end else begin
			x <= x_wrap ? '0 : x + 1'b1;
			if (x_wrap) begin
				y <= y_wrap ? '0 : y + 1'b1;
			end
		end
	end

	// flags lag the counters by one cycle
	always_ff @(posedge clk_pix_p) begin
		if (reset) begin
			de <= 1'b0;
			ctrl <= '0;
		end else begin
			de <= video_en && (x < h_active) && (y < v_active);
			ctrl.hsync <= video_en && (x >= h_sync_start) && (x < h_sync_start + h_sync);
			ctrl.vsync <= video_en && (y >= v_sync_start) && (y < v_sync_start + v_sync);
		end
	end

	a_x_in_line: assert property (@(posedge clk_pix_p) disable iff (reset)
		x <= `HDMI_POS_W'(h_total - 1));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the HDMI transmitter testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module hdmi_tb -f hdmi.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vhdmi_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1
